// File: verilog/axi_bridge_defs.svh
`ifndef AXI_BRIDGE_DEFS_SVH
`define AXI_BRIDGE_DEFS_SVH

// processor port and AXI widths
`define AXB_ADDR_W 32
`define AXB_DATA_W 32
`define AXB_ID_W   4

// one strobe bit per data byte
`define AXB_STRB_W (`AXB_DATA_W / 8)

`endif

// File: verilog/axi_bus_pkg.sv
`include "axi_bridge_defs.svh"

package axi_bus_pkg;

	typedef enum logic [1:0] {
		AXI_RESP_OKAY   = 2'b00,
		AXI_RESP_EXOKAY = 2'b01,
		AXI_RESP_SLVERR = 2'b10,
		AXI_RESP_DECERR = 2'b11
	} axi_resp_e;

	// bytes per beat, log2 coded
	typedef enum logic [2:0] {
		AXI_SIZE_1B   = 3'd0,
		AXI_SIZE_2B   = 3'd1,
		AXI_SIZE_4B   = 3'd2,
		AXI_SIZE_8B   = 3'd3,
		AXI_SIZE_16B  = 3'd4,
		AXI_SIZE_32B  = 3'd5,
		AXI_SIZE_64B  = 3'd6,
		AXI_SIZE_128B = 3'd7
	} axi_size_e;

	typedef enum logic [1:0] {
		AXI_BURST_FIXED = 2'b00,
		AXI_BURST_INCR  = 2'b01,
		AXI_BURST_WRAP  = 2'b10
	} axi_burst_e;

	typedef logic [`AXB_ID_W-1:0] axi_id_t;

endpackage

// File: verilog/sram_req_pkg.sv
`include "axi_bridge_defs.svh"

package sram_req_pkg;

	import axi_bus_pkg::*;

	// read request as handed to the read master
	typedef struct packed {
		logic [`AXB_ADDR_W-1:0] addr;
		axi_id_t                id;
	} sram_rd_t;

	// write request, full word with byte enables
	typedef struct packed {
		logic [`AXB_ADDR_W-1:0] addr;
		axi_id_t                id;
		logic [`AXB_DATA_W-1:0] data;
		logic [`AXB_STRB_W-1:0] strb;
	} sram_wr_t;

	// what comes back to the core for a read
	typedef struct packed {
		logic [`AXB_DATA_W-1:0] data;
		axi_id_t                id;
		axi_resp_e              resp;
	} sram_rret_t;

endpackage

// File: verilog/req_chan_if.sv
`timescale 1ns/1ps

interface req_chan_if #(
	parameter type payload_t = logic
);

	logic     req_valid;
	logic     req_ready;
	payload_t req;
	// one cycle pulse when the AXI response of the request is taken
	logic     done;

	modport ctrl (
		output req_valid,
		output req,
		input  req_ready,
		input  done
	);

	modport master (
		input  req_valid,
		input  req,
		output req_ready,
		output done
	);

endinterface

// File: verilog/sram_axi_ctrl.sv
`timescale 1ns/1ps
`include "axi_bridge_defs.svh"

module sram_axi_ctrl (
	input  logic                   ACLK,
	input  logic                   ARESETn,
	input  logic                   req,
	input  logic                   wr,
	input  logic [`AXB_ADDR_W-1:0] addr,
	input  axi_bus_pkg::axi_id_t   id,
	input  logic [`AXB_DATA_W-1:0] wdata,
	input  logic [`AXB_STRB_W-1:0] wstrb,
	output logic                   addr_ok,
	req_chan_if.ctrl               rd_chan,
	req_chan_if.ctrl               wr_chan
);

	import sram_req_pkg::*;

	sram_rd_t rd_req_q;
	sram_wr_t wr_req_q;
	logic     rd_pend;
	logic     wr_pend;
	logic     rd_hazard;
	logic     rd_accept;
	logic     wr_accept;

	//////////////////////////////////////////////////////////////////////
	// acceptance
	//////////////////////////////////////////////////////////////////////

	// wr_req_q still holds the address of the write in flight
	assign rd_hazard = wr_pend && (wr_req_q.addr == addr);

	// pend flags cover the staged request and the AXI transaction behind it
	assign addr_ok = wr ? (!wr_pend && wr_chan.req_ready)
	                    : (!rd_pend && rd_chan.req_ready && !rd_hazard);

	assign rd_accept = req && addr_ok && !wr;
	assign wr_accept = req && addr_ok && wr;

	assign rd_chan.req = rd_req_q;
	assign wr_chan.req = wr_req_q;

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			rd_chan.req_valid <= 1'b0;
			wr_chan.req_valid <= 1'b0;
			rd_pend           <= 1'b0;
			wr_pend           <= 1'b0;
		end else begin
			// valid holds until the master takes it
			if (rd_accept)
				rd_chan.req_valid <= 1'b1;
			else if (rd_chan.req_ready)
				rd_chan.req_valid <= 1'b0;

			if (wr_accept)
				wr_chan.req_valid <= 1'b1;
			else if (wr_chan.req_ready)
				wr_chan.req_valid <= 1'b0;

			if (rd_accept)
				rd_pend <= 1'b1;
			else if (rd_chan.done)
				rd_pend <= 1'b0;

			// a new write wins over the done of the old one
			if (wr_accept)
				wr_pend <= 1'b1;
			else if (wr_chan.done)
				wr_pend <= 1'b0;
		end
	end

	always_ff @(posedge ACLK) begin
		if (rd_accept) begin
			rd_req_q.addr <= addr;
			rd_req_q.id   <= id;
		end
		if (wr_accept) begin
			wr_req_q.addr <= addr;
			wr_req_q.id   <= id;
			wr_req_q.data <= wdata;
			wr_req_q.strb <= wstrb;
		end
	end

endmodule

// File: verilog/axi_rd_master.sv
`timescale 1ns/1ps
`include "axi_bridge_defs.svh"

module axi_rd_master (
	input  logic                     ACLK,
	input  logic                     ARESETn,
	req_chan_if.master               chan,
	output logic [`AXB_ADDR_W-1:0]   ARADDR,
	output logic [3:0]               ARLEN,
	output logic [2:0]               ARSIZE,
	output logic [1:0]               ARBURST,
	output axi_bus_pkg::axi_id_t     ARID,
	output logic                     ARVALID,
	input  logic                     ARREADY,
	input  logic [`AXB_DATA_W-1:0]   RDATA,
	input  logic [1:0]               RRESP,
	input  logic                     RLAST,
	input  axi_bus_pkg::axi_id_t     RID,
	input  logic                     RVALID,
	output logic                     RREADY,
	output sram_req_pkg::sram_rret_t ret,
	output logic                     rdata_ok
);

	import axi_bus_pkg::*;

	typedef enum logic [1:0] {
		AR_IDLE = 2'b01,
		AR_REQ  = 2'b10
	} ar_state_e;

	typedef enum logic [1:0] {
		R_IDLE = 2'b01,
		R_WAIT = 2'b10
	} r_state_e;

	ar_state_e ar_state;
	r_state_e  r_state;
	logic      chan_hs;
	logic      ar_hs;
	logic      r_last_hs;

	assign chan_hs   = chan.req_valid && chan.req_ready;
	assign ar_hs     = ARVALID && ARREADY;
	assign r_last_hs = RVALID && RREADY && RLAST;

	// no new read until both FSMs are back to idle
	assign chan.req_ready = (ar_state == AR_IDLE) && (r_state == R_IDLE);
	assign chan.done      = rdata_ok;

	// single 4 byte beat, burst code 0
	assign ARLEN   = 4'd0;
	assign ARSIZE  = AXI_SIZE_4B;
	assign ARBURST = AXI_BURST_FIXED;

	//////////////////////////////////////////////////////////////////////
	// address FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			ar_state <= AR_IDLE;
			ARVALID  <= 1'b0;
		end else begin
			case (ar_state)
				AR_IDLE: begin
					if (chan_hs) begin
						ar_state <= AR_REQ;
						ARVALID  <= 1'b1;
					end
				end
				AR_REQ: begin
					if (ar_hs) begin
						ar_state <= AR_IDLE;
						ARVALID  <= 1'b0;
					end
				end
				default: begin
					ar_state <= AR_IDLE;
					ARVALID  <= 1'b0;
				end
			endcase
		end
	end

	// stays put while AR is stalled
	always_ff @(posedge ACLK) begin
		if (chan_hs) begin
			ARADDR <= chan.req.addr;
			ARID   <= chan.req.id;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// data FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			r_state  <= R_IDLE;
			RREADY   <= 1'b0;
			rdata_ok <= 1'b0;
		end else begin
			rdata_ok <= 1'b0;
			case (r_state)
				R_IDLE: begin
					if (ar_hs) begin
						r_state <= R_WAIT;
						RREADY  <= 1'b1;
					end
				end
				R_WAIT: begin
					if (r_last_hs) begin
						r_state  <= R_IDLE;
						RREADY   <= 1'b0;
						rdata_ok <= 1'b1;
					end
				end
				default: begin
					r_state <= R_IDLE;
					RREADY  <= 1'b0;
				end
			endcase
		end
	end

	// last beat carries the word returned to the core
	always_ff @(posedge ACLK) begin
		if (r_last_hs) begin
			ret.data <= RDATA;
			ret.id   <= RID;
			ret.resp <= axi_resp_e'(RRESP);
		end
	end

endmodule

// File: verilog/axi_wr_master.sv
`timescale 1ns/1ps
`include "axi_bridge_defs.svh"

module axi_wr_master (
	input  logic                   ACLK,
	input  logic                   ARESETn,
	req_chan_if.master             chan,
	output logic [`AXB_ADDR_W-1:0] AWADDR,
	output logic [3:0]             AWLEN,
	output logic [2:0]             AWSIZE,
	output logic [1:0]             AWBURST,
	output axi_bus_pkg::axi_id_t   AWID,
	output logic                   AWVALID,
	input  logic                   AWREADY,
	output logic [`AXB_DATA_W-1:0] WDATA,
	output logic [`AXB_STRB_W-1:0] WSTRB,
	output logic                   WLAST,
	output logic                   WVALID,
	input  logic                   WREADY,
	input  axi_bus_pkg::axi_id_t   BID,
	input  logic [1:0]             BRESP,
	input  logic                   BVALID,
	output logic                   BREADY,
	output axi_bus_pkg::axi_id_t   bid,
	output axi_bus_pkg::axi_resp_e bresp,
	output logic                   wdata_ok
);

	import axi_bus_pkg::*;

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_SEND,
		WR_RESP
	} wr_state_e;

	wr_state_e state;
	logic      chan_hs;
	logic      b_hs;
	logic      aw_left;
	logic      w_left;

	assign chan_hs = chan.req_valid && chan.req_ready;
	assign b_hs    = BVALID && BREADY;
	// still waiting after this edge
	assign aw_left = AWVALID && !AWREADY;
	assign w_left  = WVALID && !WREADY;

	assign chan.req_ready = (state == WR_IDLE);
	assign chan.done      = wdata_ok;

	assign AWLEN   = 4'd0;
	assign AWSIZE  = AXI_SIZE_4B;
	assign AWBURST = AXI_BURST_FIXED;
	assign WLAST   = 1'b1;

	//////////////////////////////////////////////////////////////////////
	// AW and W go out together, B once both are through
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state    <= WR_IDLE;
			AWVALID  <= 1'b0;
			WVALID   <= 1'b0;
			BREADY   <= 1'b0;
			wdata_ok <= 1'b0;
		end else begin
			wdata_ok <= 1'b0;
			case (state)
				WR_IDLE: begin
					if (chan_hs) begin
						state   <= WR_SEND;
						AWVALID <= 1'b1;
						WVALID  <= 1'b1;
					end
				end
				WR_SEND: begin
					// each channel drops on its own ready
					if (!aw_left)
						AWVALID <= 1'b0;
					if (!w_left)
						WVALID <= 1'b0;
					if (!aw_left && !w_left) begin
						state  <= WR_RESP;
						BREADY <= 1'b1;
					end
				end
				WR_RESP: begin
					if (b_hs) begin
						state    <= WR_IDLE;
						BREADY   <= 1'b0;
						wdata_ok <= 1'b1;
					end
				end
				default: begin
					state <= WR_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge ACLK) begin
		if (chan_hs) begin
			AWADDR <= chan.req.addr;
			AWID   <= chan.req.id;
			WDATA  <= chan.req.data;
			WSTRB  <= chan.req.strb;
		end
		if (b_hs) begin
			bid   <= BID;
			bresp <= axi_resp_e'(BRESP);
		end
	end

endmodule

// File: verilog/sram_axi_bridge.sv
`timescale 1ns/1ps
`include "axi_bridge_defs.svh"

module sram_axi_bridge (
	input  logic                   ACLK,
	input  logic                   ARESETn,
	// processor side
	input  logic                   req,
	input  logic                   wr,
	input  logic [`AXB_ADDR_W-1:0] addr,
	input  logic [`AXB_ID_W-1:0]   id,
	input  logic [`AXB_DATA_W-1:0] wdata,
	input  logic [`AXB_STRB_W-1:0] wstrb,
	output logic                   addr_ok,
	output logic                   rdata_ok,
	output logic [`AXB_DATA_W-1:0] rdata,
	output logic [`AXB_ID_W-1:0]   rid,
	output logic [1:0]             rresp,
	output logic                   wdata_ok,
	output logic [`AXB_ID_W-1:0]   bid,
	output logic [1:0]             bresp,
	// AXI master
	output logic [`AXB_ADDR_W-1:0] ARADDR,
	output logic [3:0]             ARLEN,
	output logic [2:0]             ARSIZE,
	output logic [1:0]             ARBURST,
	output logic [`AXB_ID_W-1:0]   ARID,
	output logic                   ARVALID,
	input  logic                   ARREADY,
	input  logic [`AXB_DATA_W-1:0] RDATA,
	input  logic [1:0]             RRESP,
	input  logic                   RLAST,
	input  logic [`AXB_ID_W-1:0]   RID,
	input  logic                   RVALID,
	output logic                   RREADY,
	output logic [`AXB_ADDR_W-1:0] AWADDR,
	output logic [3:0]             AWLEN,
	output logic [2:0]             AWSIZE,
	output logic [1:0]             AWBURST,
	output logic [`AXB_ID_W-1:0]   AWID,
	output logic                   AWVALID,
	input  logic                   AWREADY,
	output logic [`AXB_DATA_W-1:0] WDATA,
	output logic [`AXB_STRB_W-1:0] WSTRB,
	output logic                   WLAST,
	output logic                   WVALID,
	input  logic                   WREADY,
	input  logic [`AXB_ID_W-1:0]   BID,
	input  logic [1:0]             BRESP,
	input  logic                   BVALID,
	output logic                   BREADY
);

	import sram_req_pkg::*;

	sram_rret_t rd_ret;

	req_chan_if #(.payload_t(sram_rd_t)) rd_chan ();
	req_chan_if #(.payload_t(sram_wr_t)) wr_chan ();

	// read return flattened for the core
	assign rdata = rd_ret.data;
	assign rid   = rd_ret.id;
	assign rresp = rd_ret.resp;

	sram_axi_ctrl sram_axi_ctrl_i (
		.ACLK    (ACLK),
		.ARESETn (ARESETn),
		.req     (req),
		.wr      (wr),
		.addr    (addr),
		.id      (id),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.addr_ok (addr_ok),
		.rd_chan (rd_chan.ctrl),
		.wr_chan (wr_chan.ctrl)
	);

	axi_rd_master axi_rd_master_i (
		.ACLK     (ACLK),
		.ARESETn  (ARESETn),
		.chan     (rd_chan.master),
		.ARADDR   (ARADDR),
		.ARLEN    (ARLEN),
		.ARSIZE   (ARSIZE),
		.ARBURST  (ARBURST),
		.ARID     (ARID),
		.ARVALID  (ARVALID),
		.ARREADY  (ARREADY),
		.RDATA    (RDATA),
		.RRESP    (RRESP),
		.RLAST    (RLAST),
		.RID      (RID),
		.RVALID   (RVALID),
		.RREADY   (RREADY),
		.ret      (rd_ret),
		.rdata_ok (rdata_ok)
	);

	axi_wr_master axi_wr_master_i (
		.ACLK     (ACLK),
		.ARESETn  (ARESETn),
		.chan     (wr_chan.master),
		.AWADDR   (AWADDR),
		.AWLEN    (AWLEN),
		.AWSIZE   (AWSIZE),
		.AWBURST  (AWBURST),
		.AWID     (AWID),
		.AWVALID  (AWVALID),
		.AWREADY  (AWREADY),
		.WDATA    (WDATA),
		.WSTRB    (WSTRB),
		.WLAST    (WLAST),
		.WVALID   (WVALID),
		.WREADY   (WREADY),
		.BID      (BID),
		.BRESP    (BRESP),
		.BVALID   (BVALID),
		.BREADY   (BREADY),
		.bid      (bid),
		.bresp    (bresp),
		.wdata_ok (wdata_ok)
	);

endmodule

// File: sim/sram_axi_bridge_chk.sv
`timescale 1ns/1ps
`include "axi_bridge_defs.svh"

module sram_axi_bridge_chk (
	input logic                   ACLK,
	input logic                   ARESETn,
	input logic                   ARVALID,
	input logic                   ARREADY,
	input logic [`AXB_ADDR_W-1:0] ARADDR,
	input logic [`AXB_ID_W-1:0]   ARID,
	input logic                   AWVALID,
	input logic                   AWREADY,
	input logic [`AXB_ADDR_W-1:0] AWADDR,
	input logic [`AXB_ID_W-1:0]   AWID,
	input logic                   WVALID,
	input logic                   WREADY,
	input logic [`AXB_DATA_W-1:0] WDATA,
	input logic [`AXB_STRB_W-1:0] WSTRB,
	input logic                   rdata_ok,
	input logic                   wdata_ok
);

	int fail_cnt = 0;

	// valid and payload hold until ready
	ar_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		ARVALID && !ARREADY |=> ARVALID && $stable(ARADDR) && $stable(ARID))
		else begin
			$error("ARVALID dropped or AR payload changed before ARREADY");
			fail_cnt++;
		end

	aw_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		AWVALID && !AWREADY |=> AWVALID && $stable(AWADDR) && $stable(AWID))
		else begin
			$error("AWVALID dropped or AW payload changed before AWREADY");
			fail_cnt++;
		end

	w_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		WVALID && !WREADY |=> WVALID && $stable(WDATA) && $stable(WSTRB))
		else begin
			$error("WVALID dropped or W payload changed before WREADY");
			fail_cnt++;
		end

	// return strobes are single cycle
	rdata_pulse: assert property (@(posedge ACLK) disable iff (!ARESETn)
		rdata_ok |=> !rdata_ok)
		else begin
			$error("rdata_ok high for more than one cycle");
			fail_cnt++;
		end

	wdata_pulse: assert property (@(posedge ACLK) disable iff (!ARESETn)
		wdata_ok |=> !wdata_ok)
		else begin
			$error("wdata_ok high for more than one cycle");
			fail_cnt++;
		end

endmodule

bind sram_axi_bridge sram_axi_bridge_chk chk_i (
	.ACLK     (ACLK),
	.ARESETn  (ARESETn),
	.ARVALID  (ARVALID),
	.ARREADY  (ARREADY),
	.ARADDR   (ARADDR),
	.ARID     (ARID),
	.AWVALID  (AWVALID),
	.AWREADY  (AWREADY),
	.AWADDR   (AWADDR),
	.AWID     (AWID),
	.WVALID   (WVALID),
	.WREADY   (WREADY),
	.WDATA    (WDATA),
	.WSTRB    (WSTRB),
	.rdata_ok (rdata_ok),
	.wdata_ok (wdata_ok)
);

// File: sim/sram_axi_bridge_tb.sv
`timescale 1ns/1ps
`include "axi_bridge_defs.svh"

module sram_axi_bridge_tb;

	import axi_bus_pkg::*;
	import sram_req_pkg::*;

	logic                   ACLK;
	logic                   ARESETn;
	logic                   req;
	logic                   wr;
	logic [`AXB_ADDR_W-1:0] addr;
	logic [`AXB_ID_W-1:0]   id;
	logic [`AXB_DATA_W-1:0] wdata;
	logic [`AXB_STRB_W-1:0] wstrb;
	logic                   addr_ok;
	logic                   rdata_ok;
	logic [`AXB_DATA_W-1:0] rdata;
	logic [`AXB_ID_W-1:0]   rid;
	logic [1:0]             rresp;
	logic                   wdata_ok;
	logic [`AXB_ID_W-1:0]   bid;
	logic [1:0]             bresp;
	logic [`AXB_ADDR_W-1:0] ARADDR;
	logic [3:0]             ARLEN;
	logic [2:0]             ARSIZE;
	logic [1:0]             ARBURST;
	logic [`AXB_ID_W-1:0]   ARID;
	logic                   ARVALID;
	logic                   ARREADY;
	logic [`AXB_DATA_W-1:0] RDATA;
	logic [1:0]             RRESP;
	logic                   RLAST;
	logic [`AXB_ID_W-1:0]   RID;
	logic                   RVALID;
	logic                   RREADY;
	logic [`AXB_ADDR_W-1:0] AWADDR;
	logic [3:0]             AWLEN;
	logic [2:0]             AWSIZE;
	logic [1:0]             AWBURST;
	logic [`AXB_ID_W-1:0]   AWID;
	logic                   AWVALID;
	logic                   AWREADY;
	logic [`AXB_DATA_W-1:0] WDATA;
	logic [`AXB_STRB_W-1:0] WSTRB;
	logic                   WLAST;
	logic                   WVALID;
	logic                   WREADY;
	logic [`AXB_ID_W-1:0]   BID;
	logic [1:0]             BRESP;
	logic                   BVALID;
	logic                   BREADY;

	// operations from the data file, in file order
	logic [7:0]             op_kind [$];
	logic [`AXB_ADDR_W-1:0] op_addr [$];
	axi_id_t                op_id [$];
	logic [`AXB_DATA_W-1:0] op_wdata [$];
	logic [`AXB_STRB_W-1:0] op_strb [$];

	// expected returns per direction, request order
	sram_rret_t rd_exp_q [$];
	string      rd_name_q [$];
	axi_id_t    wr_exp_q [$];
	string      wr_name_q [$];

	int          rd_seen = 0;
	int          wr_seen = 0;
	int          drv_errors = 0;
	int          ret_errors = 0;
	int          bus_errors = 0;
	int          cycles = 0;
	int          timeout_limit = 0;
	logic [31:0] rng;

	sram_axi_bridge sram_axi_bridge_i (.*);

	initial begin
		ACLK = 1'b0;
		forever #50 ACLK = ~ACLK;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// slave wait of 0 to 3 extra cycles
	task automatic pick_delay(output logic [1:0] d);
		rng = xorshift32(rng);
		d = rng[1:0];
	endtask

	task automatic check_rret(input string name, input sram_rret_t exp,
	                          input sram_rret_t act);
		if (act !== exp) begin
			ret_errors++;
			$display("FAIL %s: expected data %h id %h resp %s, actual data %h id %h resp %s",
			         name, exp.data, exp.id, exp.resp.name(),
			         act.data, act.id, act.resp.name());
		end
	endtask

	task automatic check_wresp(input string name, input axi_id_t exp_id,
	                           input axi_resp_e exp_resp, input axi_id_t act_id,
	                           input axi_resp_e act_resp);
		if (act_id !== exp_id || act_resp !== exp_resp) begin
			ret_errors++;
			$display("FAIL %s: expected id %h resp %s, actual id %h resp %s",
			         name, exp_id, exp_resp.name(), act_id, act_resp.name());
		end
	endtask

	// single beat of 4 bytes, burst code 0
	task automatic check_addr_beat(input string name, input logic [3:0] act_len,
	                               input axi_size_e act_size, input axi_burst_e act_burst);
		logic [3:0] exp_len;
		axi_size_e  exp_size;
		axi_burst_e exp_burst;
		exp_len   = 4'd0;
		exp_size  = AXI_SIZE_4B;
		exp_burst = axi_burst_e'(2'd0);
		if (act_len !== exp_len || act_size !== exp_size || act_burst !== exp_burst) begin
			bus_errors++;
			$display("FAIL %s: expected len,size,burst %h,%h,%h, actual %h,%h,%h",
			         name, exp_len, exp_size, exp_burst, act_len, act_size, act_burst);
		end
	endtask

	task automatic check_last(input string name, input logic act_last);
		if (act_last !== 1'b1) begin
			bus_errors++;
			$display("FAIL %s: expected last 1, actual %b", name, act_last);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// AXI slave memory model
	//////////////////////////////////////////////////////////////////////

	initial begin : slave_model
		logic [`AXB_DATA_W-1:0] mem [0:63];
		logic [1:0]             ar_wait;
		logic [1:0]             r_wait;
		logic [1:0]             aw_wait;
		logic [1:0]             w_wait;
		logic [1:0]             b_wait;
		logic                   ar_fire;
		logic                   ar_stall;
		logic                   aw_fire;
		logic                   aw_stall;
		logic                   w_fire;
		logic                   w_stall;
		logic                   r_fire;
		logic                   b_fire;
		logic                   rd_busy;
		logic                   aw_got;
		logic                   w_got;
		logic [`AXB_DATA_W-1:0] rd_word;
		axi_id_t                rd_id;
		logic [5:0]             wr_idx;
		axi_id_t                wr_id;
		logic [`AXB_DATA_W-1:0] wr_data;
		logic [`AXB_DATA_W-1:0] wr_mask;

		// fill value carries the word index
		for (int i = 0; i < 64; i++)
			mem[i[5:0]] = 32'h5a5a_0000 + i;
		ARREADY = 1'b0;
		RVALID  = 1'b0;
		RDATA   = '0;
		RRESP   = AXI_RESP_OKAY;
		RLAST   = 1'b0;
		RID     = '0;
		AWREADY = 1'b0;
		WREADY  = 1'b0;
		BVALID  = 1'b0;
		BID     = '0;
		BRESP   = AXI_RESP_OKAY;
		rd_busy = 1'b0;
		aw_got  = 1'b0;
		w_got   = 1'b0;
		rd_word = '0;
		rd_id   = '0;
		wr_idx  = '0;
		wr_id   = '0;
		wr_data = '0;
		wr_mask = '0;
		rng     = 32'h87ce_94ce;
		pick_delay(ar_wait);
		pick_delay(r_wait);
		pick_delay(aw_wait);
		pick_delay(w_wait);
		pick_delay(b_wait);
		forever begin
			@(posedge ACLK);
			ar_fire  = ARVALID && ARREADY;
			ar_stall = ARVALID && !ARREADY;
			aw_fire  = AWVALID && AWREADY;
			aw_stall = AWVALID && !AWREADY;
			w_fire   = WVALID && WREADY;
			w_stall  = WVALID && !WREADY;
			r_fire   = RVALID && RREADY;
			b_fire   = BVALID && BREADY;
			if (ar_fire) begin
				check_addr_beat($sformatf("AR beat %h", ARADDR), ARLEN,
				                axi_size_e'(ARSIZE), axi_burst_e'(ARBURST));
				rd_word = mem[ARADDR[7:2]];
				rd_id   = ARID;
				rd_busy = 1'b1;
			end
			if (aw_fire) begin
				check_addr_beat($sformatf("AW beat %h", AWADDR), AWLEN,
				                axi_size_e'(AWSIZE), axi_burst_e'(AWBURST));
				wr_idx = AWADDR[7:2];
				wr_id  = AWID;
				aw_got = 1'b1;
			end
			if (w_fire) begin
				check_last($sformatf("W beat %h", WDATA), WLAST);
				wr_data = WDATA;
				wr_mask = {{8{WSTRB[3]}}, {8{WSTRB[2]}}, {8{WSTRB[1]}}, {8{WSTRB[0]}}};
				w_got   = 1'b1;
			end
			// write lands only with its B handshake, so an early read sees old data
			if (b_fire) begin
				mem[wr_idx] = (mem[wr_idx] & ~wr_mask) | (wr_data & wr_mask);
				aw_got = 1'b0;
				w_got  = 1'b0;
			end
			if (r_fire)
				rd_busy = 1'b0;
			#1;
			if (ar_fire) begin
				ARREADY = 1'b0;
				pick_delay(ar_wait);
			end else if (ar_stall) begin
				if (ar_wait == 2'd0)
					ARREADY = 1'b1;
				else
					ar_wait = ar_wait - 2'd1;
			end
			if (aw_fire) begin
				AWREADY = 1'b0;
				pick_delay(aw_wait);
			end else if (aw_stall) begin
				if (aw_wait == 2'd0)
					AWREADY = 1'b1;
				else
					aw_wait = aw_wait - 2'd1;
			end
			if (w_fire) begin
				WREADY = 1'b0;
				pick_delay(w_wait);
			end else if (w_stall) begin
				if (w_wait == 2'd0)
					WREADY = 1'b1;
				else
					w_wait = w_wait - 2'd1;
			end
			if (r_fire) begin
				RVALID = 1'b0;
				RLAST  = 1'b0;
				pick_delay(r_wait);
			end else if (rd_busy && !RVALID) begin
				if (r_wait == 2'd0) begin
					RVALID = 1'b1;
					RDATA  = rd_word;
					RID    = rd_id;
					RRESP  = AXI_RESP_OKAY;
					RLAST  = 1'b1;
				end else begin
					r_wait = r_wait - 2'd1;
				end
			end
			if (b_fire) begin
				BVALID = 1'b0;
				pick_delay(b_wait);
			end else if (aw_got && w_got && !BVALID) begin
				if (b_wait == 2'd0) begin
					BVALID = 1'b1;
					BID    = wr_id;
					BRESP  = AXI_RESP_OKAY;
				end else begin
					b_wait = b_wait - 2'd1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// return monitor
	//////////////////////////////////////////////////////////////////////

	always @(posedge ACLK) begin
		sram_rret_t act_ret;
		if (ARESETn && rdata_ok) begin
			act_ret.data = rdata;
			act_ret.id   = rid;
			act_ret.resp = axi_resp_e'(rresp);
			if (rd_seen < rd_exp_q.size()) begin
				check_rret(rd_name_q[rd_seen], rd_exp_q[rd_seen], act_ret);
			end else begin
				ret_errors++;
				$display("ERROR: rdata_ok pulsed with no read outstanding");
			end
			rd_seen++;
		end
		if (ARESETn && wdata_ok) begin
			if (wr_seen < wr_exp_q.size()) begin
				check_wresp(wr_name_q[wr_seen], wr_exp_q[wr_seen], AXI_RESP_OKAY,
				            bid, axi_resp_e'(bresp));
			end else begin
				ret_errors++;
				$display("ERROR: wdata_ok pulsed with no write outstanding");
			end
			wr_seen++;
		end
	end

	always @(posedge ACLK) begin
		cycles++;
		if (cycles > timeout_limit) begin
			$display("ERROR: run did not finish within %0d cycles", timeout_limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin : driver
		int                     fd;
		int                     rc;
		int                     total;
		string                  line;
		logic [7:0]             kind;
		logic [`AXB_ADDR_W-1:0] f_addr;
		axi_id_t                f_id;
		logic [`AXB_DATA_W-1:0] f_wdata;
		logic [`AXB_STRB_W-1:0] f_strb;
		logic [`AXB_DATA_W-1:0] f_expect;
		sram_rret_t             exp_ret;

		ARESETn = 1'b0;
		req     = 1'b0;
		wr      = 1'b0;
		addr    = '0;
		id      = '0;
		wdata   = '0;
		wstrb   = '0;

		fd = $fopen("sim/sram_axi_testdata.txt", "r");
		if (fd == 0) begin
			drv_errors++;
			$display("ERROR: could not open sim/sram_axi_testdata.txt");
		end
		while (fd != 0 && !$feof(fd)) begin
			line = "";
			rc = $fgets(line, fd);
			if (rc > 0 && line.getc(0) != "#") begin
				rc = $sscanf(line, "%c %h %h %h %h %h",
				             kind, f_addr, f_id, f_wdata, f_strb, f_expect);
				if (rc == 6) begin
					op_kind.push_back(kind);
					op_addr.push_back(f_addr);
					op_id.push_back(f_id);
					op_wdata.push_back(f_wdata);
					op_strb.push_back(f_strb);
					if (kind == "W") begin
						wr_exp_q.push_back(f_id);
						wr_name_q.push_back($sformatf("op %0d write %h", op_kind.size(), f_addr));
					end else begin
						exp_ret.data = f_expect;
						exp_ret.id   = f_id;
						exp_ret.resp = AXI_RESP_OKAY;
						rd_exp_q.push_back(exp_ret);
						rd_name_q.push_back($sformatf("op %0d read %h", op_kind.size(), f_addr));
					end
				end
			end
		end
		if (fd != 0)
			$fclose(fd);
		timeout_limit = op_kind.size() * 40 + 5;

		repeat (5) @(posedge ACLK);
		#1;
		ARESETn = 1'b1;

		// nothing may move on AXI or the return side before a request
		repeat (2) begin
			@(posedge ACLK);
			if (ARVALID || AWVALID || WVALID || RREADY || BREADY || rdata_ok || wdata_ok) begin
				drv_errors++;
				$display("ERROR: AXI valid, ready or return pulse high after reset with no request");
			end
		end
		#1;

		for (int n = 0; n < op_kind.size(); n++) begin
			req   = 1'b1;
			wr    = (op_kind[n] == "W");
			addr  = op_addr[n];
			id    = op_id[n];
			wdata = op_wdata[n];
			wstrb = op_strb[n];
			@(posedge ACLK);
			while (!addr_ok)
				@(posedge ACLK);
			#1;
		end
		req = 1'b0;

		while (rd_seen < rd_exp_q.size() || wr_seen < wr_exp_q.size())
			@(posedge ACLK);
		// room for stray return pulses
		repeat (8) @(posedge ACLK);

		total = drv_errors + ret_errors + bus_errors + sram_axi_bridge_i.chk_i.fail_cnt;
		$display("reads %0d of %0d, writes %0d of %0d, errors %0d",
		         rd_seen, rd_exp_q.size(), wr_seen, wr_exp_q.size(), total);
		if (total == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: sim/sram_axi_testdata.txt
# kind addr id wdata strb expect, all hex except kind
# W writes wdata under strb, R expects the word in the last column
W 00000010 1 11223344 f 00000000
R 00000010 2 00000000 0 11223344
W 00000020 3 deadbeef 5 00000000
R 00000020 4 00000000 0 5aad00ef
W 00000010 5 aabbccdd 3 00000000
R 00000010 6 00000000 0 1122ccdd
W 00000030 7 cafef00d f 00000000
R 00000030 8 00000000 0 cafef00d
W 00000034 9 01020304 c 00000000
R 00000034 a 00000000 0 0102000d
R 00000050 b 00000000 0 5a5a0014
W 00000040 c 99887766 8 00000000
R 00000040 d 00000000 0 995a0010
W 00000044 e 12345678 f 00000000
W 00000048 f 87654321 f 00000000
R 00000044 0 00000000 0 12345678

// File: vlog.f
+incdir+verilog
verilog/axi_bus_pkg.sv
verilog/sram_req_pkg.sv
verilog/req_chan_if.sv
verilog/sram_axi_ctrl.sv
verilog/axi_rd_master.sv
verilog/axi_wr_master.sv
verilog/sram_axi_bridge.sv
sim/sram_axi_bridge_chk.sv
sim/sram_axi_bridge_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= sram_axi_bridge_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
DATA      ?= sim/sram_axi_testdata.txt
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard verilog/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(DATA)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
